// File: design/sadPkg.sv
`default_nettype none

package sadPkg;

    // Block geometry
    localparam int blockDim = 4;
    localparam int blockPixels = blockDim * blockDim;

    // Candidate row and column width, sized for the largest frame
    localparam int posWidth = 8;

    localparam int busAddrWidth = 12;
    localparam int busDataWidth = 32;

    // Register word addresses
    localparam logic [busAddrWidth-1:0] regControl = 'd0;
    localparam logic [busAddrWidth-1:0] regStatus = 'd1;
    localparam logic [busAddrWidth-1:0] regMinSad = 'd2;
    localparam logic [busAddrWidth-1:0] regBestPos = 'd3;

    // Pixel windows in the word address map
    localparam logic [busAddrWidth-1:0] frameBase = 'd256;
    localparam logic [busAddrWidth-1:0] windowBase = 'd512;

    // Sixteen terms need four extra bits over one pixel
    function automatic int sadWidth(input int pixWidth);
        return pixWidth + 4;
    endfunction

endpackage

`default_nettype wire

// File: design/sadRegs.sv
`timescale 1ns/10ps
`default_nettype none

module sadRegs #(
    parameter int frameDim = 16,
    parameter int pixelWidth = 8
) (
    input  logic                                    Clk,
    input  logic                                    rstN,
    input  logic                                    cyc,
    input  logic                                    stb,
    input  logic                                    we,
    input  logic [sadPkg::busAddrWidth-1:0]         adr,
    input  logic [sadPkg::busDataWidth-1:0]         datW,
    output logic [sadPkg::busDataWidth-1:0]         datR,
    output logic                                    ack,
    input  logic                                    done,
    input  logic [sadPkg::sadWidth(pixelWidth)-1:0] minSad,
    input  logic [sadPkg::posWidth-1:0]             bestRow,
    input  logic [sadPkg::posWidth-1:0]             bestCol,
    output logic                                    start,
    output logic                                    frameWe,
    output logic [$clog2(frameDim*frameDim)-1:0]    frameIdx,
    output logic                                    windowWe,
    output logic [$clog2(sadPkg::blockPixels)-1:0]  windowIdx,
    output logic [pixelWidth-1:0]                   pixData
);
    import sadPkg::*;

    localparam int frameWords = frameDim * frameDim;
    localparam int frameIdxWidth = $clog2(frameWords);
    localparam int windowIdxWidth = $clog2(blockPixels);

    logic                              busy;
    logic                              doneFlag;
    logic [sadWidth(pixelWidth)-1:0]   resultSad;
    logic [posWidth-1:0]               resultRow;
    logic [posWidth-1:0]               resultCol;
    logic                              writeAck;
    logic                              locked;
    logic                              frameHit;
    logic                              windowHit;
    logic [busDataWidth-1:0]           readValue;

    // Writes take effect in the ack cycle, while the host still holds the bus
    assign writeAck = ack && cyc && stb && we;
    // Also locked in the start cycle, before busy has risen
    assign locked = busy || start;

    assign frameHit = (adr >= frameBase) && (adr < frameBase + frameWords);
    assign windowHit = (adr >= windowBase) && (adr < windowBase + blockPixels);

    assign frameIdx = frameIdxWidth'(adr - frameBase);
    assign windowIdx = windowIdxWidth'(adr - windowBase);
    assign pixData = datW[pixelWidth-1:0];
    assign frameWe = writeAck && frameHit && !locked;
    assign windowWe = writeAck && windowHit && !locked;

    always_comb begin
        case (adr)
            regStatus:  readValue = busDataWidth'({doneFlag, busy});
            regMinSad:  readValue = busDataWidth'(resultSad);
            regBestPos: readValue = busDataWidth'({resultRow, resultCol});
            default:    readValue = '0;
        endcase
    end

    // One-cycle ack, read data sampled with the request
    always_ff @(posedge Clk) begin
        if (!rstN) begin
            ack <= 1'b0;
        end else begin
            ack <= cyc && stb && !ack;
        end
        if (cyc && stb && !ack) begin
            datR <= readValue;
        end
    end

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            start <= 1'b0;
            busy <= 1'b0;
            doneFlag <= 1'b0;
            resultSad <= '1;
            resultRow <= '0;
            resultCol <= '0;
        end else begin
            start <= writeAck && (adr == regControl) && datW[0] && !locked;
            if (start) begin
                busy <= 1'b1;
                doneFlag <= 1'b0;
            end else if (done) begin
                busy <= 1'b0;
                doneFlag <= 1'b1;
                resultSad <= minSad;
                resultRow <= bestRow;
                resultCol <= bestCol;
            end
        end
    end

    ackSinglePulse: assert property (@(posedge Clk) disable iff (!rstN) ack |=> !ack);

endmodule

`default_nettype wire

// File: design/candidateScan.sv
`timescale 1ns/10ps
`default_nettype none

module candidateScan #(
    parameter int frameDim = 16
) (
    input  logic                        Clk,
    input  logic                        rstN,
    input  logic                        start,
    output logic                        candValid,
    output logic [sadPkg::posWidth-1:0] candRow,
    output logic [sadPkg::posWidth-1:0] candCol,
    output logic                        candLast
);
    import sadPkg::*;

    // Highest origin in either direction
    localparam logic [posWidth-1:0] lastPos = posWidth'(frameDim - blockDim);

    logic colEnd;

    assign colEnd = (candCol == lastPos);
    assign candLast = candValid && colEnd && (candRow == lastPos);

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            candValid <= 1'b0;
            candRow <= '0;
            candCol <= '0;
        end else if (!candValid) begin
            if (start) begin
                candValid <= 1'b1;
                candRow <= '0;
                candCol <= '0;
            end
        end else if (candLast) begin
            candValid <= 1'b0;
        end else if (colEnd) begin
            candCol <= '0;
            candRow <= candRow + 1'b1;
        end else begin
            candCol <= candCol + 1'b1;
        end
    end

    colInRange: assert property (@(posedge Clk) disable iff (!rstN)
        candValid |-> (candCol <= lastPos) && (candRow <= lastPos));

endmodule

`default_nettype wire

// File: design/pixelStore.sv
`timescale 1ns/10ps
`default_nettype none

module pixelStore #(
    parameter int frameDim = 16,
    parameter int pixelWidth = 8
) (
    input  logic                                             Clk,
    input  logic                                             rstN,
    input  logic                                             frameWe,
    input  logic [$clog2(frameDim*frameDim)-1:0]             frameIdx,
    input  logic                                             windowWe,
    input  logic [$clog2(sadPkg::blockPixels)-1:0]           windowIdx,
    input  logic [pixelWidth-1:0]                            pixData,
    input  logic                                             candValid,
    input  logic [sadPkg::posWidth-1:0]                      candRow,
    input  logic [sadPkg::posWidth-1:0]                      candCol,
    input  logic                                             candLast,
    output logic                                             blkValid,
    output logic [sadPkg::posWidth-1:0]                      blkRow,
    output logic [sadPkg::posWidth-1:0]                      blkCol,
    output logic                                             blkLast,
    output logic [sadPkg::blockPixels-1:0][pixelWidth-1:0]   framePix,
    output logic [sadPkg::blockPixels-1:0][pixelWidth-1:0]   windowPix
);
    import sadPkg::*;

    localparam int frameIdxWidth = $clog2(frameDim * frameDim);

    logic [pixelWidth-1:0]    frameMem [frameDim*frameDim];
    logic [pixelWidth-1:0]    windowReg [blockPixels];
    logic [frameIdxWidth-1:0] blockIdx [blockPixels];

    always_ff @(posedge Clk) begin
        if (frameWe) begin
            frameMem[frameIdx] <= pixData;
        end
        if (windowWe) begin
            windowReg[windowIdx] <= pixData;
        end
    end

    // Pixel k of the block sits at row k/4, column k%4 from the origin
    always_comb begin
        for (int k = 0; k < blockPixels; k++) begin
            blockIdx[k] = frameIdxWidth'((candRow + k / blockDim) * frameDim
                                         + candCol + k % blockDim);
        end
    end

    always_ff @(posedge Clk) begin
        for (int k = 0; k < blockPixels; k++) begin
            framePix[k] <= frameMem[blockIdx[k]];
        end
        blkRow <= candRow;
        blkCol <= candCol;
    end

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            blkValid <= 1'b0;
            blkLast <= 1'b0;
        end else begin
            blkValid <= candValid;
            blkLast <= candValid && candLast;
        end
    end

    // Window is frozen while a scan runs
    always_comb begin
        for (int k = 0; k < blockPixels; k++) begin
            windowPix[k] = windowReg[k];
        end
    end

endmodule

`default_nettype wire

// File: design/sadDatapath.sv
`timescale 1ns/10ps
`default_nettype none

module sadDatapath #(
    parameter int pixelWidth = 8
) (
    input  logic                                           Clk,
    input  logic                                           rstN,
    input  logic                                           blkValid,
    input  logic [sadPkg::posWidth-1:0]                    blkRow,
    input  logic [sadPkg::posWidth-1:0]                    blkCol,
    input  logic                                           blkLast,
    input  logic [sadPkg::blockPixels-1:0][pixelWidth-1:0] framePix,
    input  logic [sadPkg::blockPixels-1:0][pixelWidth-1:0] windowPix,
    output logic                                           sadValid,
    output logic [sadPkg::posWidth-1:0]                    sadRow,
    output logic [sadPkg::posWidth-1:0]                    sadCol,
    output logic                                           sadLast,
    output logic [sadPkg::sadWidth(pixelWidth)-1:0]        sadValue
);
    import sadPkg::*;

    logic [pixelWidth-1:0]             absDiff [blockPixels];
    logic [pixelWidth+1:0]             partSum [blockDim];
    logic [2:0]                        validPipe;
    logic [2:0]                        lastPipe;
    logic [2:0][posWidth-1:0]          rowPipe;
    logic [2:0][posWidth-1:0]          colPipe;

    // Stage 1
    always_ff @(posedge Clk) begin
        for (int k = 0; k < blockPixels; k++) begin
            if (framePix[k] > windowPix[k]) begin
                absDiff[k] <= framePix[k] - windowPix[k];
            end else begin
                absDiff[k] <= windowPix[k] - framePix[k];
            end
        end
    end

    // Stage 2, one partial sum per block row
    always_ff @(posedge Clk) begin
        for (int g = 0; g < blockDim; g++) begin
            partSum[g] <= absDiff[4*g] + absDiff[4*g+1]
                          + absDiff[4*g+2] + absDiff[4*g+3];
        end
    end

    // Stage 3
    always_ff @(posedge Clk) begin
        sadValue <= partSum[0] + partSum[1] + partSum[2] + partSum[3];
    end

    // Position and flags follow their item down the pipe
    always_ff @(posedge Clk) begin
        rowPipe <= {rowPipe[1:0], blkRow};
        colPipe <= {colPipe[1:0], blkCol};
    end

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            validPipe <= '0;
            lastPipe <= '0;
        end else begin
            validPipe <= {validPipe[1:0], blkValid};
            lastPipe <= {lastPipe[1:0], blkLast};
        end
    end

    assign sadValid = validPipe[2];
    assign sadLast = lastPipe[2];
    assign sadRow = rowPipe[2];
    assign sadCol = colPipe[2];

endmodule

`default_nettype wire

// File: design/minTracker.sv
`timescale 1ns/10ps
`default_nettype none

module minTracker #(
    parameter int pixelWidth = 8
) (
    input  logic                                    Clk,
    input  logic                                    rstN,
    input  logic                                    start,
    input  logic                                    sadValid,
    input  logic [sadPkg::posWidth-1:0]             sadRow,
    input  logic [sadPkg::posWidth-1:0]             sadCol,
    input  logic                                    sadLast,
    input  logic [sadPkg::sadWidth(pixelWidth)-1:0] sadValue,
    output logic [sadPkg::sadWidth(pixelWidth)-1:0] minSad,
    output logic [sadPkg::posWidth-1:0]             bestRow,
    output logic [sadPkg::posWidth-1:0]             bestCol,
    output logic                                    done
);
    logic better;

    // Strict compare keeps the earliest candidate on a tie
    assign better = sadValid && (sadValue < minSad);

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            minSad <= '1;
            done <= 1'b0;
        end else begin
            done <= sadValid && sadLast;
            if (start) begin
                minSad <= '1;
            end else if (better) begin
                minSad <= sadValue;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (better && !start) begin
            bestRow <= sadRow;
            bestCol <= sadCol;
        end
    end

    minNonIncreasing: assert property (@(posedge Clk) disable iff (!rstN)
        !start |=> (minSad <= $past(minSad)));

endmodule

`default_nettype wire

// File: design/sadTop.sv
`timescale 1ns/10ps
`default_nettype none

module sadTop #(
    parameter int frameDim = 16,
    parameter int pixelWidth = 8
) (
    input  logic                            Clk,
    input  logic                            rstN,
    input  logic                            cyc,
    input  logic                            stb,
    input  logic                            we,
    input  logic [sadPkg::busAddrWidth-1:0] adr,
    input  logic [sadPkg::busDataWidth-1:0] datW,
    output logic [sadPkg::busDataWidth-1:0] datR,
    output logic                            ack
);
    import sadPkg::*;

    localparam int frameIdxWidth = $clog2(frameDim * frameDim);
    localparam int windowIdxWidth = $clog2(blockPixels);

    logic                                   start;
    logic                                   frameWe;
    logic [frameIdxWidth-1:0]               frameIdx;
    logic                                   windowWe;
    logic [windowIdxWidth-1:0]              windowIdx;
    logic [pixelWidth-1:0]                  pixData;
    logic                                   candValid;
    logic [posWidth-1:0]                    candRow;
    logic [posWidth-1:0]                    candCol;
    logic                                   candLast;
    logic                                   blkValid;
    logic [posWidth-1:0]                    blkRow;
    logic [posWidth-1:0]                    blkCol;
    logic                                   blkLast;
    logic [blockPixels-1:0][pixelWidth-1:0] framePix;
    logic [blockPixels-1:0][pixelWidth-1:0] windowPix;
    logic                                   sadValid;
    logic [posWidth-1:0]                    sadRow;
    logic [posWidth-1:0]                    sadCol;
    logic                                   sadLast;
    logic [sadWidth(pixelWidth)-1:0]        sadValue;
    logic [sadWidth(pixelWidth)-1:0]        minSad;
    logic [posWidth-1:0]                    bestRow;
    logic [posWidth-1:0]                    bestCol;
    logic                                   done;

    sadRegs #(.frameDim(frameDim), .pixelWidth(pixelWidth)) regsInst (
        .Clk(Clk), .rstN(rstN), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .datW(datW), .datR(datR), .ack(ack), .done(done), .minSad(minSad),
        .bestRow(bestRow), .bestCol(bestCol), .start(start), .frameWe(frameWe),
        .frameIdx(frameIdx), .windowWe(windowWe), .windowIdx(windowIdx), .pixData(pixData)
    );

    candidateScan #(.frameDim(frameDim)) scanInst (
        .Clk(Clk), .rstN(rstN), .start(start), .candValid(candValid),
        .candRow(candRow), .candCol(candCol), .candLast(candLast)
    );

    pixelStore #(.frameDim(frameDim), .pixelWidth(pixelWidth)) storeInst (
        .Clk(Clk), .rstN(rstN), .frameWe(frameWe), .frameIdx(frameIdx),
        .windowWe(windowWe), .windowIdx(windowIdx), .pixData(pixData),
        .candValid(candValid), .candRow(candRow), .candCol(candCol), .candLast(candLast),
        .blkValid(blkValid), .blkRow(blkRow), .blkCol(blkCol), .blkLast(blkLast),
        .framePix(framePix), .windowPix(windowPix)
    );

    sadDatapath #(.pixelWidth(pixelWidth)) datapathInst (
        .Clk(Clk), .rstN(rstN), .blkValid(blkValid), .blkRow(blkRow), .blkCol(blkCol),
        .blkLast(blkLast), .framePix(framePix), .windowPix(windowPix),
        .sadValid(sadValid), .sadRow(sadRow), .sadCol(sadCol), .sadLast(sadLast),
        .sadValue(sadValue)
    );

    minTracker #(.pixelWidth(pixelWidth)) trackerInst (
        .Clk(Clk), .rstN(rstN), .start(start), .sadValid(sadValid), .sadRow(sadRow),
        .sadCol(sadCol), .sadLast(sadLast), .sadValue(sadValue), .minSad(minSad),
        .bestRow(bestRow), .bestCol(bestCol), .done(done)
    );

endmodule

`default_nettype wire

// File: tests/sadChecker.sv
`timescale 1ns/10ps
`default_nettype none

module sadChecker #(
    parameter int frameDim = 16,
    parameter int pixelWidth = 8
) (
    input  logic                            Clk,
    input  logic                            rstN,
    input  logic                            cyc,
    input  logic                            stb,
    input  logic                            we,
    input  logic [sadPkg::busAddrWidth-1:0] adr,
    input  logic [sadPkg::busDataWidth-1:0] datW,
    input  logic [sadPkg::busDataWidth-1:0] datR,
    input  logic                            ack,
    output int                              checkCount,
    output int                              errorCount
);
    import sadPkg::*;

    localparam int frameWords = frameDim * frameDim;
    localparam int lastPos = frameDim - blockDim;

    logic [pixelWidth-1:0] frameMirror [frameWords];
    logic [pixelWidth-1:0] windowMirror [blockPixels];
    logic                  busyModel;
    logic                  doneModel;
    logic                  ackDue;
    int                    expSad;
    int                    expRow;
    int                    expCol;
    int                    pendSad;
    int                    pendRow;
    int                    pendCol;

    // Exhaustive search over all origins where the first strictly smaller SAD wins
    function automatic void referenceSearch(output int bestSad, output int bestRow,
                                            output int bestCol);
        int sad;
        int f;
        int w;
        bestSad = 1 << 30;
        bestRow = 0;
        bestCol = 0;
        for (int r = 0; r <= lastPos; r++) begin
            for (int c = 0; c <= lastPos; c++) begin
                sad = 0;
                for (int k = 0; k < blockPixels; k++) begin
                    f = frameMirror[(r + k / blockDim) * frameDim + c + k % blockDim];
                    w = windowMirror[k];
                    sad += (f > w) ? f - w : w - f;
                end
                if (sad < bestSad) begin
                    bestSad = sad;
                    bestRow = r;
                    bestCol = c;
                end
            end
        end
    endfunction

    task automatic compareValue(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("MISMATCH at %0t ns: %s expected 0x%0h, got 0x%0h",
                     $time, name, expected, actual);
        end
    endtask

    initial begin
        checkCount = 0;
        errorCount = 0;
        for (int i = 0; i < frameWords; i++) begin
            frameMirror[i] = '0;
        end
        for (int k = 0; k < blockPixels; k++) begin
            windowMirror[k] = '0;
        end
    end

    // Ack is due one cycle after a new request and lasts one cycle
    always @(negedge Clk) begin
        if (!rstN) begin
            ackDue = 1'b0;
        end else begin
            if (ackDue || ack) begin
                compareValue("ack", 32'(ackDue), 32'(ack));
            end
            ackDue = cyc && stb && !ack;
        end
    end

    // Bus signals are settled by the falling edge of the ack cycle
    always @(negedge Clk) begin
        if (!rstN) begin
            busyModel = 1'b0;
            doneModel = 1'b0;
            expSad = (1 << (pixelWidth + 4)) - 1;
            expRow = 0;
            expCol = 0;
        end else if (ack && cyc && stb && we) begin
            if (adr == regControl) begin
                if (datW[0] && !busyModel) begin
                    busyModel = 1'b1;
                    doneModel = 1'b0;
                    // Pixels are frozen for the whole scan
                    referenceSearch(pendSad, pendRow, pendCol);
                end
            end else if (!busyModel && adr >= frameBase && adr < frameBase + frameWords) begin
                frameMirror[adr - frameBase] = datW[pixelWidth-1:0];
            end else if (!busyModel && adr >= windowBase && adr < windowBase + blockPixels) begin
                windowMirror[adr - windowBase] = datW[pixelWidth-1:0];
            end
        end else if (ack && cyc && stb) begin
            case (adr)
                regStatus: begin
                    // Once the scan finishes the result registers hold the new search
                    if (busyModel && datR === 32'd2) begin
                        busyModel = 1'b0;
                        doneModel = 1'b1;
                        expSad = pendSad;
                        expRow = pendRow;
                        expCol = pendCol;
                    end
                    compareValue("regStatus", {30'd0, doneModel, busyModel}, datR);
                end
                regMinSad: compareValue("regMinSad", expSad, datR);
                regBestPos: compareValue("regBestPos", (expRow << 8) | expCol, datR);
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: tests/sadTb.sv
`timescale 1ns/10ps
`default_nettype none

module sadTb;
    import sadPkg::*;

    localparam int frameDim = 16;
    localparam int ackLimit = 20;
    localparam int pollLimit = 400;

    logic                    Clk;
    logic                    rstN;
    logic                    cyc;
    logic                    stb;
    logic                    we;
    logic [busAddrWidth-1:0] adr;
    logic [busDataWidth-1:0] datW;
    logic [busDataWidth-1:0] datR;
    logic                    ack;
    int                      checkCount;
    int                      errorCount;
    int                      timeoutCount;
    int                      lastErrors;
    logic [31:0]             lfsrState;
    logic [7:0]              frameCopy [frameDim*frameDim];
    logic [busDataWidth-1:0] readData;

    sadTop uut (
        .Clk(Clk), .rstN(rstN), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .datW(datW), .datR(datR), .ack(ack)
    );

    sadChecker monitorInst (
        .Clk(Clk), .rstN(rstN), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .datW(datW), .datR(datR), .ack(ack),
        .checkCount(checkCount), .errorCount(errorCount)
    );

    always #4 Clk = ~Clk;

    // Right-shifting Galois LFSR with taps 32 30 26 25
    function automatic logic lfsrBit();
        logic out;
        out = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (out) begin
            lfsrState = lfsrState ^ 32'hA300_0000;
        end
        return out;
    endfunction

    function automatic logic [7:0] randomPixel();
        logic [7:0] value;
        for (int b = 0; b < 8; b++) begin
            value[b] = lfsrBit();
        end
        return value;
    endfunction

    task automatic endRun();
        $display("Checks run %0d, passed %0d, failed %0d",
                 checkCount, checkCount - errorCount, errorCount + timeoutCount);
        if (errorCount == 0 && timeoutCount == 0 && checkCount > 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    endtask

    task automatic abortRun(input string what);
        $display("Timeout: %s", what);
        timeoutCount++;
        endRun();
    endtask

    task automatic busAccess(input logic isWrite, input logic [busAddrWidth-1:0] addr,
                             input logic [busDataWidth-1:0] wData,
                             output logic [busDataWidth-1:0] rData);
        int waited;
        @(posedge Clk);
        #1;
        cyc = 1'b1;
        stb = 1'b1;
        we = isWrite;
        adr = addr;
        datW = wData;
        waited = 0;
        @(negedge Clk);
        while (!ack && waited < ackLimit) begin
            @(negedge Clk);
            waited++;
        end
        if (!ack) begin
            abortRun($sformatf("no ack for bus access to address %0d", addr));
        end else begin
            rData = datR;
            @(posedge Clk);
            #1;
            cyc = 1'b0;
            stb = 1'b0;
            we = 1'b0;
        end
    endtask

    task automatic busWrite(input logic [busAddrWidth-1:0] addr,
                            input logic [busDataWidth-1:0] wData);
        logic [busDataWidth-1:0] unused;
        busAccess(1'b1, addr, wData, unused);
    endtask

    task automatic busRead(input logic [busAddrWidth-1:0] addr,
                           output logic [busDataWidth-1:0] rData);
        busAccess(1'b0, addr, '0, rData);
    endtask

    task automatic pollDone();
        int polls;
        logic [busDataWidth-1:0] status;
        polls = 0;
        status = '0;
        while (!status[1] && polls < pollLimit) begin
            busRead(regStatus, status);
            polls++;
        end
        if (!status[1]) begin
            abortRun("done bit was never set after start");
        end
    endtask

    // Frame is either flat at one level or random
    task automatic loadFrame(input logic flat, input logic [7:0] level);
        for (int i = 0; i < frameDim * frameDim; i++) begin
            frameCopy[i] = flat ? level : randomPixel();
            busWrite(busAddrWidth'(frameBase + i), frameCopy[i]);
        end
    endtask

    task automatic loadWindowFromFrame(input int row, input int col);
        for (int k = 0; k < blockPixels; k++) begin
            busWrite(busAddrWidth'(windowBase + k),
                     frameCopy[(row + k / blockDim) * frameDim + col + k % blockDim]);
        end
    endtask

    task automatic loadRandomWindow();
        for (int k = 0; k < blockPixels; k++) begin
            busWrite(busAddrWidth'(windowBase + k), randomPixel());
        end
    endtask

    task automatic runSearch();
        busWrite(regControl, 32'd1);
        pollDone();
        busRead(regMinSad, readData);
        busRead(regBestPos, readData);
    endtask

    task automatic finishTest(input string name);
        $display("%s finished with %0d mismatches", name, errorCount - lastErrors);
        lastErrors = errorCount;
    endtask

    initial begin
        Clk = 1'b0;
        rstN = 1'b0;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        adr = '0;
        datW = '0;
        timeoutCount = 0;
        lastErrors = 0;
        lfsrState = 32'h5446_7d52;
        repeat (8) @(posedge Clk);
        #1;
        rstN = 1'b1;

        busRead(regStatus, readData);
        busRead(regMinSad, readData);
        busRead(regBestPos, readData);
        finishTest("reset state");

        loadFrame(1'b0, 8'h00);
        loadWindowFromFrame(7, 10);
        runSearch();
        finishTest("planted match");

        for (int round = 0; round < 3; round++) begin
            loadFrame(1'b0, 8'h00);
            loadRandomWindow();
            runSearch();
        end
        finishTest("random search");

        loadFrame(1'b1, 8'h5a);
        loadRandomWindow();
        runSearch();
        finishTest("tie-break");

        // Zero match early in the scan, so a late restart or a window change would lose it
        loadFrame(1'b0, 8'h00);
        loadWindowFromFrame(1, 0);
        busWrite(regControl, 32'd1);
        // Everything after the first start lands while the scan runs
        for (int k = 0; k < 4; k++) begin
            busWrite(busAddrWidth'(frameBase + 37 * k), randomPixel());
            busWrite(busAddrWidth'(windowBase + k), randomPixel());
        end
        busWrite(regControl, 32'd1);
        pollDone();
        busRead(regStatus, readData);
        busRead(regMinSad, readData);
        busRead(regBestPos, readData);
        finishTest("writes while busy");

        endRun();
    end

endmodule

`default_nettype wire

// File: filelist.f
design/sadPkg.sv
design/sadRegs.sv
design/candidateScan.sv
design/pixelStore.sv
design/sadDatapath.sv
design/minTracker.sv
design/sadTop.sv
tests/sadChecker.sv
tests/sadTb.sv
